//--- bench/xbus_tb.sv
// table-driven testbench for the xbus memory slice, run as the simulation top
`default_nettype none

module xbus_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import xbus_pkg::*;

   localparam int ack_timeout = 40;

   // expected latency codes in the table
   localparam int lat_none = 0;
   localparam int lat_ram  = -1;

   typedef struct packed {
      logic [addr_bits-1:0] addr;
      logic                 write;
      logic                 use_lfsr;
      logic [data_bits-1:0] data;
      logic                 from_shadow;
      logic [data_bits-1:0] exp_data;
      logic                 exp_decode;
      int                   exp_lat;
   } row_t;

   logic      clk;
   logic      reset;
   xbus_req_t bus_req;
   xbus_rsp_t bus_rsp;

   row_t  rows  [$];
   string names [$];

   // reference model of the slice
   logic [data_bits-1:0] shadow [store_words];
   logic [wait_bits-1:0] model_wait;

   logic [31:0] lfsr;
   int          pass_count;
   int          fail_count;

   xbus_top xbus_top_inst (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // fibonacci taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic draw_word(output logic [31:0] w);
      w = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr = lfsr_next(lfsr);
         w    = {w[30:0], lfsr[0]};
      end
   endtask

   // ack latency of a ram access for a given wait-state count
   // the ack comes wait states plus one cycles after req is sampled
   function automatic int ram_latency(input logic [wait_bits-1:0] ws);
      return int'(ws) + 1;
   endfunction

   // only store-backed ram words are read from the shadow
   function automatic logic [data_bits-1:0] model_read(input logic [addr_bits-1:0] addr);
      return shadow[addr[store_bits-1:0]];
   endfunction

   // called once per acked access
   task automatic model_update(input logic [addr_bits-1:0] addr, input logic write,
                               input logic [data_bits-1:0] data);
      if (addr < ram_limit) begin
         if (write && int'(addr) < store_words) begin
            shadow[addr[store_bits-1:0]] = data;
         end
      end else if (write && addr == cfg_base) begin
         model_wait = data[wait_bits-1:0];
      end
   endtask

   task automatic add_row(input string name, input logic [addr_bits-1:0] addr,
                          input logic write, input logic use_lfsr,
                          input logic [data_bits-1:0] data, input logic from_shadow,
                          input logic [data_bits-1:0] exp_data, input logic exp_decode,
                          input int exp_lat);
      row_t r;
      r.addr        = addr;
      r.write       = write;
      r.use_lfsr    = use_lfsr;
      r.data        = data;
      r.from_shadow = from_shadow;
      r.exp_data    = exp_data;
      r.exp_decode  = exp_decode;
      r.exp_lat     = exp_lat;
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic build_table();
      // name, addr, write, lfsr, data, from shadow, exp data, exp decode, exp latency
      // write then read back at reset wait states
      add_row("ram_wr_low", 22'o17, 1'b1, 1'b1, '0, 1'b0, '0, 1'b1, lat_ram);
      add_row("ram_wr_last", 22'd4095, 1'b1, 1'b1, '0, 1'b0, '0, 1'b1, lat_ram);
      add_row("ram_rd_low", 22'o17, 1'b0, 1'b0, '0, 1'b1, '0, 1'b1, lat_ram);
      add_row("ram_rd_last", 22'd4095, 1'b0, 1'b0, '0, 1'b1, '0, 1'b1, lat_ram);
      add_row("ram_rewr_low", 22'o17, 1'b1, 1'b1, '0, 1'b0, '0, 1'b1, lat_ram);
      add_row("ram_rerd_low", 22'o17, 1'b0, 1'b0, '0, 1'b1, '0, 1'b1, lat_ram);
      // decoded but not backed by the store
      add_row("beyond_wr", 22'd4096, 1'b1, 1'b0, 32'h1234_5678, 1'b0, '0, 1'b1, lat_ram);
      add_row("beyond_rd", 22'd4096, 1'b0, 1'b0, '0, 1'b0, '1, 1'b1, lat_ram);
      add_row("beyond_top_rd", 22'o1077_7777, 1'b0, 1'b0, '0, 1'b0, '1, 1'b1, lat_ram);
      // wait states 0
      add_row("ws0_wr", cfg_base, 1'b1, 1'b0, 32'd0, 1'b0, '0, 1'b1, 1);
      add_row("ws0_rd", cfg_base, 1'b0, 1'b0, '0, 1'b0, 32'd0, 1'b1, 1);
      add_row("ws0_ram_wr", 22'o200, 1'b1, 1'b1, '0, 1'b0, '0, 1'b1, lat_ram);
      add_row("ws0_ram_rd", 22'o200, 1'b0, 1'b0, '0, 1'b1, '0, 1'b1, lat_ram);
      // wait states 7
      add_row("ws7_wr", cfg_base, 1'b1, 1'b0, 32'd7, 1'b0, '0, 1'b1, 1);
      add_row("ws7_rd", cfg_base, 1'b0, 1'b0, '0, 1'b0, 32'd7, 1'b1, 1);
      add_row("ws7_ram_wr", 22'o3777, 1'b1, 1'b1, '0, 1'b0, '0, 1'b1, lat_ram);
      add_row("ws7_ram_rd", 22'o3777, 1'b0, 1'b0, '0, 1'b1, '0, 1'b1, lat_ram);
      // gap between ram and registers, never acks
      add_row("unmapped_rd", 22'o1200_0000, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, lat_none);
      add_row("unmapped_wr", 22'o1777_7600, 1'b1, 1'b0, '1, 1'b0, '0, 1'b0, lat_none);
      // transfer counter, cleared then three ram accesses
      add_row("cnt_clear", cfg_base + 22'd1, 1'b1, 1'b0, 32'hdead_beef, 1'b0, '0, 1'b1, 1);
      add_row("cnt_zero", cfg_base + 22'd1, 1'b0, 1'b0, '0, 1'b0, 32'd0, 1'b1, 1);
      add_row("ws2_wr", cfg_base, 1'b1, 1'b0, 32'd2, 1'b0, '0, 1'b1, 1);
      add_row("cnt_ram_wr", 22'o5, 1'b1, 1'b1, '0, 1'b0, '0, 1'b1, lat_ram);
      add_row("cnt_ram_rd", 22'o5, 1'b0, 1'b0, '0, 1'b1, '0, 1'b1, lat_ram);
      add_row("cnt_beyond_rd", 22'd5000, 1'b0, 1'b0, '0, 1'b0, '1, 1'b1, lat_ram);
      add_row("cnt_three", cfg_base + 22'd1, 1'b0, 1'b0, '0, 1'b0, 32'd3, 1'b1, 1);
   endtask

   // starts on a falling edge, ends on the falling edge that drops req
   task automatic apply_row(input int idx);
      row_t                 r;
      logic [data_bits-1:0] wdata;
      logic [data_bits-1:0] exp_data;
      logic [data_bits-1:0] rdata;
      int                   exp_lat;
      int                   lat;
      logic                 acked;
      logic                 decode_bad;
      logic                 bad_decode_val;
      logic                 ok;

      r              = rows[idx];
      ok             = 1'b1;
      acked          = 1'b0;
      decode_bad     = 1'b0;
      bad_decode_val = 1'b0;
      lat            = 0;
      rdata          = '0;
      wdata          = r.data;
      if (r.use_lfsr) begin
         draw_word(wdata);
      end
      exp_lat  = (r.exp_lat == lat_ram) ? ram_latency(model_wait) : r.exp_lat;
      exp_data = r.from_shadow ? model_read(r.addr) : r.exp_data;

      bus_req.addr  = r.addr;
      bus_req.data  = wdata;
      bus_req.write = r.write;
      bus_req.req   = 1'b1;

      // lat counts rising edges from the one sampling req to the one sampling ack
      while (!acked && lat < ack_timeout) begin
         @(negedge clk);
         lat++;
         if (bus_rsp.decode !== r.exp_decode) begin
            decode_bad     = 1'b1;
            bad_decode_val = bus_rsp.decode;
         end
         if (bus_rsp.ack === 1'b1) begin
            acked = 1'b1;
            rdata = bus_rsp.data;
         end
      end

      // req stays up through the ack edge
      if (acked) begin
         @(negedge clk);
         if (bus_rsp.ack !== 1'b0) begin
            $display("%s: ack stayed high for more than one cycle", names[idx]);
            ok = 1'b0;
         end
      end
      bus_req.req   = 1'b0;
      bus_req.write = 1'b0;

      if (exp_lat == lat_none) begin
         if (acked) begin
            $display("%s: unmapped address was acked after %0d cycles", names[idx], lat);
            ok = 1'b0;
         end
      end else if (!acked) begin
         $display("%s: no ack within %0d cycles", names[idx], ack_timeout);
         ok = 1'b0;
      end else begin
         if (lat != exp_lat) begin
            $display("CHECK FAILED %s latency expected %0d actual %0d",
                     names[idx], exp_lat, lat);
            ok = 1'b0;
         end
         if (!r.write && rdata !== exp_data) begin
            $display("CHECK FAILED %s data expected %h actual %h",
                     names[idx], exp_data, rdata);
            ok = 1'b0;
         end
      end
      if (decode_bad) begin
         $display("CHECK FAILED %s decode expected %b actual %b",
                  names[idx], r.exp_decode, bad_decode_val);
         ok = 1'b0;
      end

      if (acked) begin
         model_update(r.addr, r.write, wdata);
      end
      if (ok) begin
         pass_count++;
         $display("pass %-14s addr %o lat %0d data %h", names[idx], r.addr, lat, rdata);
      end else begin
         fail_count++;
         $display("fail %-14s addr %o", names[idx], r.addr);
      end
   endtask

   initial begin
      reset       = 1'b1;
      bus_req     = '0;
      lfsr        = 32'hb3e4_1d3e;
      pass_count  = 0;
      fail_count  = 0;
      model_wait  = wait_reset;
      build_table();

      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // one idle edge between accesses
      foreach (rows[i]) begin
         @(negedge clk);
         apply_row(i);
      end

      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
design/xbus_pkg.sv
design/xbus_ram.sv
design/ram_controller.sv
design/xbus_cfg_regs.sv
design/xbus_resp_mux.sv
design/xbus_top.sv
bench/xbus_tb.sv

//--- design/ram_controller.sv
// memory controller emulating sdram latency with a programmable wait-state count over a word store
`default_nettype none

module ram_controller (
   input  logic                                clk,
   input  logic                                reset,
   input  xbus_pkg::mem_req_t                  mem_req,
   input  logic [xbus_pkg::wait_bits-1:0]      wait_states,
   output xbus_pkg::mem_rsp_t                  mem_rsp,
   output logic                                xfer_done
);
   import xbus_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_wait,
      st_respond
   } state_t;

   state_t               state;
   logic [wait_bits-1:0] count;

   // access captured at the sampling edge
   logic [addr_bits-1:0] addr_q;
   logic [data_bits-1:0] data_q;
   logic                 write_q;

   logic [data_bits-1:0] read_word;
   logic [data_bits-1:0] store [store_words];

   logic                 start;
   logic                 to_respond;
   logic [addr_bits-1:0] look_addr;
   logic                 look_in_range;
   logic                 addr_q_in_range;

   assign start = mem_req.rd | mem_req.wr;

   // respond is entered straight from idle when no wait states are set,
   // otherwise once the down-counter has run out
   assign to_respond = (state == st_idle && start && wait_states == '0) ||
                       (state == st_wait && count == '0);

   // in idle the access is not captured yet, so look at the live address
   assign look_addr       = (state == st_idle) ? mem_req.addr : addr_q;
   assign look_in_range   = look_addr < addr_bits'(store_words);
   assign addr_q_in_range = addr_q < addr_bits'(store_words);

   // sequencer
   // the sampling edge itself is the first of the wait-state cycles
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
         count <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  count <= wait_states - 1'b1;
                  state <= (wait_states == '0) ? st_respond : st_wait;
               end
            end
            st_wait: begin
               if (count == '0) begin
                  state <= st_respond;
               end else begin
                  count <= count - 1'b1;
               end
            end
            st_respond: begin
               state <= st_idle;
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // capture the request, the master may change data once it sees ack
   always_ff @(posedge clk) begin
      if (state == st_idle && start) begin
         addr_q  <= mem_req.addr;
         data_q  <= mem_req.data;
         write_q <= mem_req.wr;
      end
   end

   // store access
   // read word is loaded as respond is entered, write lands at the end of done
   always_ff @(posedge clk) begin
      if (to_respond) begin
         read_word <= look_in_range ? store[look_addr[store_bits-1:0]] : '1;
      end
      if (state == st_respond && write_q && addr_q_in_range) begin
         store[addr_q[store_bits-1:0]] <= data_q;
      end
   end

   assign mem_rsp = '{
      data:  read_word,
      ready: (state == st_respond) & ~write_q,
      done:  (state == st_respond) & write_q
   };

   // one pulse per finished access, read or write
   assign xfer_done = state == st_respond;

endmodule

`default_nettype wire

//--- design/xbus_cfg_regs.sv
// register slave at the top of the xbus map holding the wait-state count and transfer counter
`default_nettype none

module xbus_cfg_regs (
   input  logic                             clk,
   input  logic                             reset,
   input  xbus_pkg::xbus_req_t              bus_req,
   input  logic                             xfer_done,
   output logic [xbus_pkg::wait_bits-1:0]   wait_states,
   output xbus_pkg::xbus_rsp_t              cfg_rsp
);
   import xbus_pkg::*;

   logic                 sel_wait;
   logic                 sel_count;
   logic                 cfg_decode;
   logic                 ack_q;
   logic                 wr_wait;
   logic                 wr_count;
   logic [wait_bits-1:0] wait_q;
   logic [data_bits-1:0] count_q;
   logic [data_bits-1:0] read_data;

   assign sel_wait   = bus_req.addr == cfg_base;
   assign sel_count  = bus_req.addr == cfg_base + addr_bits'(1);
   assign cfg_decode = sel_wait | sel_count;

   // request is still held during the ack cycle, so writes use the live bus
   assign wr_wait  = ack_q & bus_req.req & bus_req.write & sel_wait;
   assign wr_count = ack_q & bus_req.req & bus_req.write & sel_count;

   // one cycle to ack, never two acks for one held request
   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= bus_req.req & cfg_decode & ~ack_q;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wait_q <= wait_reset;
      end else if (wr_wait) begin
         wait_q <= bus_req.data[wait_bits-1:0];
      end
   end

   // any write clears, and the clear beats a coinciding transfer
   always_ff @(posedge clk) begin
      if (reset) begin
         count_q <= '0;
      end else if (wr_count) begin
         count_q <= '0;
      end else if (xfer_done) begin
         count_q <= count_q + 1'b1;
      end
   end

   // wait count reads back zero-extended
   assign read_data = sel_wait ? data_bits'(wait_q) : count_q;

   assign wait_states = wait_q;

   assign cfg_rsp = '{
      data:   read_data,
      ack:    ack_q,
      decode: cfg_decode
   };

endmodule

`default_nettype wire

//--- design/xbus_pkg.sv
// bus widths, address map and request/response structs shared by the xbus slaves and bench
`default_nettype none

package xbus_pkg;

   // bus geometry
   localparam int addr_bits = 22;
   localparam int data_bits = 32;

   // address map
   // everything below ram_limit belongs to the ram slave
   localparam logic [addr_bits-1:0] ram_limit = 22'o1100_0000;

   // words actually backed by the controller store
   localparam int store_words = 4096;
   localparam int store_bits  = $clog2(store_words);

   // wait-state register, transfer counter sits one word above it
   localparam logic [addr_bits-1:0] cfg_base = 22'o1777_7700;

   // controller wait states
   localparam int                   wait_bits  = 4;
   localparam logic [wait_bits-1:0] wait_reset = 4'd2;

   // master request, held until ack
   typedef struct packed {
      logic [addr_bits-1:0] addr;
      logic [data_bits-1:0] data;
      logic                 req;
      logic                 write;
   } xbus_req_t;

   // slave answer
   // ack is a one-cycle pulse, decode follows the address only
   typedef struct packed {
      logic [data_bits-1:0] data;
      logic                 ack;
      logic                 decode;
   } xbus_rsp_t;

   // level strobes from the ram slave down to the controller
   typedef struct packed {
      logic [addr_bits-1:0] addr;
      logic [data_bits-1:0] data;
      logic                 rd;
      logic                 wr;
   } mem_req_t;

   // controller answer, ready for reads and done for writes
   typedef struct packed {
      logic [data_bits-1:0] data;
      logic                 ready;
      logic                 done;
   } mem_rsp_t;

endpackage

`default_nettype wire

//--- design/xbus_ram.sv
// ram slave on the xbus, decodes the low address space and drives controller strobes
`default_nettype none

module xbus_ram (
   input  logic                clk,
   input  logic                reset,
   input  xbus_pkg::xbus_req_t bus_req,
   input  xbus_pkg::mem_rsp_t  mem_rsp,
   output xbus_pkg::mem_req_t  mem_req,
   output xbus_pkg::xbus_rsp_t ram_rsp
);
   import xbus_pkg::*;

   logic ram_decode;
   logic rd;
   logic wr;
   logic ack;

   // decoded range is larger than the store
   // the controller answers the top part with all ones
   assign ram_decode = bus_req.addr < ram_limit;

   assign rd = bus_req.req & ram_decode & ~bus_req.write;
   assign wr = bus_req.req & ram_decode & bus_req.write;

   // ack straight from the controller pulses, qualified by the live strobe
   assign ack = (wr & mem_rsp.done) | (rd & mem_rsp.ready);

   // address and data go down unchanged
   assign mem_req = '{
      addr: bus_req.addr,
      data: bus_req.data,
      rd:   rd,
      wr:   wr
   };

   assign ram_rsp = '{
      data:   mem_rsp.data,
      ack:    ack,
      decode: ram_decode
   };

endmodule

`default_nettype wire

//--- design/xbus_resp_mux.sv
// response select for the xbus, passes on the answer of whichever slave decodes the address
`default_nettype none

module xbus_resp_mux (
   input  xbus_pkg::xbus_rsp_t ram_rsp,
   input  xbus_pkg::xbus_rsp_t cfg_rsp,
   output xbus_pkg::xbus_rsp_t bus_rsp
);

   // the two address ranges never overlap, so the order here is arbitrary
   // an unmapped address gives all zeros and decode low, so it never acks
   always_comb begin
      if (ram_rsp.decode) begin
         bus_rsp = ram_rsp;
      end else if (cfg_rsp.decode) begin
         bus_rsp = cfg_rsp;
      end else begin
         bus_rsp = '0;
      end
   end

endmodule

`default_nettype wire

//--- design/xbus_top.sv
// top level of the xbus memory slice, wiring both slaves, the memory controller and the response select
`default_nettype none

module xbus_top (
   input  logic                clk,
   input  logic                reset,
   input  xbus_pkg::xbus_req_t bus_req,
   output xbus_pkg::xbus_rsp_t bus_rsp
);
   import xbus_pkg::*;

   // ram slave to controller
   mem_req_t mem_req;
   mem_rsp_t mem_rsp;

   // slave answers into the select
   xbus_rsp_t ram_rsp;
   xbus_rsp_t cfg_rsp;

   // register block steering the controller
   logic [wait_bits-1:0] wait_states;
   logic                 xfer_done;

   xbus_ram xbus_ram_inst (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .mem_rsp (mem_rsp),
      .mem_req (mem_req),
      .ram_rsp (ram_rsp)
   );

   ram_controller ram_controller_inst (
      .clk         (clk),
      .reset       (reset),
      .mem_req     (mem_req),
      .wait_states (wait_states),
      .mem_rsp     (mem_rsp),
      .xfer_done   (xfer_done)
   );

   xbus_cfg_regs xbus_cfg_regs_inst (
      .clk         (clk),
      .reset       (reset),
      .bus_req     (bus_req),
      .xfer_done   (xfer_done),
      .wait_states (wait_states),
      .cfg_rsp     (cfg_rsp)
   );

   xbus_resp_mux xbus_resp_mux_inst (
      .ram_rsp (ram_rsp),
      .cfg_rsp (cfg_rsp),
      .bus_rsp (bus_rsp)
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the xbus testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f compile.f --top-module xbus_tb -o xbus_sim \
   && ./obj_dir/xbus_sim > sim.log 2>&1 \
   || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "^TEST PASSED$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
